// File: Makefile
# Verilator build and run for the video output stage

VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
TOP       ?= vidout_tb
FILELIST  ?= vidout.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: source/line_buffer.sv
// ping-pong line memory for the scan doubler
// one bank takes the incoming line while the other is read back
`timescale 1ns/100ps
`include "vidout_macros.svh"

module line_buffer (
   input  logic                  clk,
   input  logic                  wr_en_i,
   input  logic                  bank_i,
   input  vidout_pkg::hcount_t     wr_addr_i,
   input  vidout_pkg::hcount_t     rd_addr_i,
   input  vidout_pkg::filt_color_t wr_r_i,
   input  vidout_pkg::filt_color_t wr_g_i,
   input  vidout_pkg::filt_color_t wr_b_i,
   output vidout_pkg::filt_color_t rd_r_o,
   output vidout_pkg::filt_color_t rd_g_o,
   output vidout_pkg::filt_color_t rd_b_o
);
   import vidout_pkg::*;

   localparam int TOTAL_DEPTH = 2 * `VID_BUF_DEPTH;

   filt_color_t mem_r [TOTAL_DEPTH];
   filt_color_t mem_g [TOTAL_DEPTH];
   filt_color_t mem_b [TOTAL_DEPTH];

   // bank bit on top of the pixel address
   logic [$clog2(TOTAL_DEPTH)-1:0] wr_idx, rd_idx;

   assign wr_idx = {bank_i, wr_addr_i};
   assign rd_idx = {~bank_i, rd_addr_i};

   always_ff @(posedge clk) begin
      if (wr_en_i) begin
         mem_r[wr_idx] <= wr_r_i;
         mem_g[wr_idx] <= wr_g_i;
         mem_b[wr_idx] <= wr_b_i;
      end
   end

   // registered read from the opposite bank
   always_ff @(posedge clk) begin
      rd_r_o <= mem_r[rd_idx];
      rd_g_o <= mem_g[rd_idx];
      rd_b_o <= mem_b[rd_idx];
   end

endmodule

// File: source/rgb_ypbpr.sv
// output stage
// optional RGB to YPbPr matrix, cut to DAC width
// picks composite or separate sync for the monitor cable
`timescale 1ns/100ps
`include "vidout_macros.svh"

module rgb_ypbpr (
   input  logic                  clk,
   input  logic                  rst_i,
   input  logic                  ypbpr_i,
   input  logic                  no_csync_i,
   input  logic                  scan2x_enb_i,
   input  vidout_pkg::full_color_t r_i,
   input  vidout_pkg::full_color_t g_i,
   input  vidout_pkg::full_color_t b_i,
   input  logic                  hs_i,
   input  logic                  vs_i,
   input  logic                  de_i,
   output vidout_pkg::dac_color_t  r_o,
   output vidout_pkg::dac_color_t  g_o,
   output vidout_pkg::dac_color_t  b_o,
   output logic                  hs_o,
   output logic                  vs_o,
   output logic                  de_o
);
   import vidout_pkg::*;

   logic [15:0]        y_sum;
   logic signed [17:0] pb_sum, pr_sum;
   full_color_t        y8, pb8, pr8;
   logic               csync, use_csync;

   // 8-bit fixed point matrix, colour difference terms signed
   always_comb begin
      y_sum  = 16'd77 * r_i + 16'd150 * g_i + 16'd29 * b_i;
      pb_sum = 18'sd128 * $signed({10'd0, b_i}) - 18'sd43 * $signed({10'd0, r_i})
             - 18'sd85 * $signed({10'd0, g_i});
      pr_sum = 18'sd128 * $signed({10'd0, r_i}) - 18'sd107 * $signed({10'd0, g_i})
             - 18'sd21 * $signed({10'd0, b_i});
      y8     = y_sum[15:8];
      // floor of sum/256, recentred on 128
      pb8    = pb_sum[15:8] + 8'd128;
      pr8    = pr_sum[15:8] + 8'd128;
   end

   always_ff @(posedge clk) begin
      if (ypbpr_i) begin
         r_o <= pr8[7 -: `VID_DW];
         g_o <= y8[7 -: `VID_DW];
         b_o <= pb8[7 -: `VID_DW];
      end else begin
         r_o <= r_i[7 -: `VID_DW];
         g_o <= g_i[7 -: `VID_DW];
         b_o <= b_i[7 -: `VID_DW];
      end
   end

   // scart and component want csync on hs with vs tied high
   assign csync     = hs_i ^ vs_i;
   assign use_csync = ypbpr_i | (scan2x_enb_i & ~no_csync_i);

   always_ff @(posedge clk) begin
      if (rst_i) begin
         hs_o <= 1'b0;
         vs_o <= 1'b0;
         de_o <= 1'b0;
      end else begin
         hs_o <= use_csync ? csync : hs_i;
         vs_o <= use_csync ? 1'b1 : vs_i;
         de_o <= de_i;
      end
   end

endmodule

// File: source/scan2x_ctrl.sv
// scan doubler control
// measures each input line from its hsync, addresses the ping-pong buffer
// and regenerates sync and blanking for two output half-lines per line
// bypass mode forwards the input timing one pixel late
`timescale 1ns/100ps

module scan2x_ctrl (
   input  logic              clk,
   input  logic              rst_i,
   input  logic              pxl_cen_i,
   input  logic              pxl2_cen_i,
   input  logic              scan2x_enb_i,
   input  logic              hs_i,
   input  logic              vs_i,
   input  logic              hb_i,
   input  logic              vb_i,
   output vidout_pkg::hcount_t wr_addr_o,
   output vidout_pkg::hcount_t rd_addr_o,
   output logic              wr_en_o,
   output logic              bank_o,
   output logic              odd_line_o,
   output logic              x2_hs_o,
   output logic              x2_vs_o,
   output logic              x2_hb_o,
   output logic              x2_vb_o,
   output logic              x2_cen_o
);
   import vidout_pkg::*;

   x2_state_t state;
   logic      hs_q, hb_q;
   logic      hs_rise, hs_fall, hb_rise, hb_fall;
   logic      line_start, run_x2;
   logic      bank_q, odd_q, odd_nxt;
   logic      vb_cap, vb_line;
   hcount_t   hcnt, line_len, hs_wid, act_beg, act_end;
   hcount_t   p_q, p_nxt;

   // edges of the input timing, seen for a whole input pixel
   assign hs_rise = hs_i & ~hs_q;
   assign hs_fall = ~hs_i & hs_q;
   assign hb_rise = hb_i & ~hb_q;
   assign hb_fall = ~hb_i & hb_q;

   assign line_start = pxl_cen_i & hs_rise;
   assign run_x2     = (state == X2_RUN) | ((state == X2_MEASURE) & hs_rise);

   // write side, a line starts at address 0 on the hsync rise
   assign wr_en_o   = pxl_cen_i;
   assign wr_addr_o = hs_rise ? '0 : hcnt;

   // new bank only on the write cycle itself
   // in bypass the write lands in the bank read on the next clock
   assign bank_o = bank_q ^ (pxl_cen_i & (scan2x_enb_i | hs_rise));

   assign rd_addr_o  = p_q;
   assign odd_line_o = odd_q;
   assign x2_cen_o   = scan2x_enb_i ? pxl_cen_i : pxl2_cen_i;

   // next output pixel, two half-lines per input line
   always_comb begin
      p_nxt   = p_q + 1'b1;
      odd_nxt = odd_q;
      if (line_start) begin
         p_nxt   = '0;
         odd_nxt = 1'b0;
      end else if (p_q == line_len - 1'b1) begin
         p_nxt   = '0;
         odd_nxt = 1'b1;
      end
   end

   // input line measurement
   always_ff @(posedge clk) begin
      if (rst_i) begin
         state    <= X2_SEEK;
         hs_q     <= 1'b0;
         hb_q     <= 1'b1;
         hcnt     <= '0;
         bank_q   <= 1'b0;
         line_len <= '0;
         hs_wid   <= '0;
         act_beg  <= '0;
         act_end  <= '0;
         vb_cap   <= 1'b1;
         vb_line  <= 1'b1;
      end else if (pxl_cen_i) begin
         hs_q <= hs_i;
         hb_q <= hb_i;
         hcnt <= wr_addr_o + 1'b1;
         if (!scan2x_enb_i) bank_q <= bank_o;
         if (hs_fall) hs_wid <= wr_addr_o;
         // active window and its vblank level, replayed on the next line
         if (hb_fall) begin
            act_beg <= wr_addr_o;
            vb_cap  <= vb_i;
         end
         if (hb_rise) act_end <= wr_addr_o;
         if (hs_rise) begin
            line_len <= hcnt;
            vb_line  <= vb_cap;
         end
         case (state)
            X2_SEEK:    if (hs_rise) state <= X2_MEASURE;
            X2_MEASURE: if (hs_rise) state <= X2_RUN;
            default:    state <= X2_RUN;
         endcase
      end
   end

   // read address and output timing
   always_ff @(posedge clk) begin
      if (rst_i) begin
         p_q     <= '0;
         odd_q   <= 1'b0;
         x2_hs_o <= 1'b0;
         x2_vs_o <= 1'b0;
         x2_hb_o <= 1'b1;
         x2_vb_o <= 1'b1;
      end else if (scan2x_enb_i) begin
         odd_q <= 1'b0;
         if (pxl_cen_i) begin
            p_q     <= wr_addr_o;
            x2_hs_o <= hs_i;
            x2_vs_o <= vs_i;
            x2_hb_o <= hb_i;
            x2_vb_o <= vb_i;
         end
      end else if (pxl2_cen_i) begin
         if (run_x2) begin
            p_q     <= p_nxt;
            odd_q   <= odd_nxt;
            x2_hs_o <= p_nxt < hs_wid;
            x2_vs_o <= vs_i;
            x2_hb_o <= (p_nxt < act_beg) | (p_nxt >= act_end);
            x2_vb_o <= line_start ? vb_cap : vb_line;
         end else begin
            // nothing measured yet, keep the monitor blanked
            p_q     <= '0;
            odd_q   <= 1'b0;
            x2_hs_o <= 1'b0;
            x2_vs_o <= 1'b0;
            x2_hb_o <= 1'b1;
            x2_vb_o <= 1'b1;
         end
      end
   end

endmodule

// File: source/scanline_shade.sv
// scanline shader
// widens colour to 8 bits and dims every odd output line
`timescale 1ns/100ps

module scanline_shade (
   input  logic                  clk,
   input  logic                  rst_i,
   input  logic                  cen_i,
   input  logic                  odd_line_i,
   input  vidout_pkg::sl_mode_t    sl_mode_i,
   input  vidout_pkg::filt_color_t r_i,
   input  vidout_pkg::filt_color_t g_i,
   input  vidout_pkg::filt_color_t b_i,
   input  logic                  hs_i,
   input  logic                  vs_i,
   input  logic                  hb_i,
   input  logic                  vb_i,
   output vidout_pkg::full_color_t r_o,
   output vidout_pkg::full_color_t g_o,
   output vidout_pkg::full_color_t b_o,
   output logic                  hs_o,
   output logic                  vs_o,
   output logic                  hb_o,
   output logic                  vb_o,
   output logic                  de_o
);
   import vidout_pkg::*;

   // msbs repeated into the new lsbs, then minus mode quarters on odd lines
   function automatic full_color_t shade(input filt_color_t c, input logic odd,
                                         input sl_mode_t mode);
      full_color_t w;
      full_color_t q;
      w = {c, c[4:2]};
      q = w >> 2;
      if (odd) w = w - q * mode;
      return w;
   endfunction

   always_ff @(posedge clk) begin
      if (cen_i) begin
         r_o <= shade(r_i, odd_line_i, sl_mode_i);
         g_o <= shade(g_i, odd_line_i, sl_mode_i);
         b_o <= shade(b_i, odd_line_i, sl_mode_i);
      end
   end

   // timing delayed with the colour
   always_ff @(posedge clk) begin
      if (rst_i) begin
         hs_o <= 1'b0;
         vs_o <= 1'b0;
         hb_o <= 1'b1;
         vb_o <= 1'b1;
         de_o <= 1'b0;
      end else if (cen_i) begin
         hs_o <= hs_i;
         vs_o <= vs_i;
         hb_o <= hb_i;
         vb_o <= vb_i;
         de_o <= ~hb_i & ~vb_i;
      end
   end

endmodule

// File: source/vid_bw_filter.sv
// analog bandwidth filter
// two-tap smoothing of each colour channel, mimics a soft video cable
// sync and blanking registered alongside so everything keeps its pixel
`timescale 1ns/100ps

module vid_bw_filter (
   input  logic                  clk,
   input  logic                  rst_i,
   input  logic                  pxl_cen_i,
   input  logic                  bw_en_i,
   input  vidout_pkg::game_color_t r_i,
   input  vidout_pkg::game_color_t g_i,
   input  vidout_pkg::game_color_t b_i,
   input  logic                  hs_i,
   input  logic                  vs_i,
   input  logic                  hb_i,
   input  logic                  vb_i,
   output vidout_pkg::filt_color_t r_o,
   output vidout_pkg::filt_color_t g_o,
   output vidout_pkg::filt_color_t b_o,
   output logic                  hs_o,
   output logic                  vs_o,
   output logic                  hb_o,
   output logic                  vb_o
);
   import vidout_pkg::*;

   // previous sample of each channel
   game_color_t r_prev, g_prev, b_prev;

   // sum of two samples, or widen with the msb copied down
   function automatic filt_color_t smooth(input game_color_t cur, input game_color_t prev,
                                          input logic en);
      filt_color_t s;
      if (en) s = {1'b0, cur} + {1'b0, prev};
      else s = {cur, cur[$bits(cur)-1]};
      return s;
   endfunction

   always_ff @(posedge clk) begin
      if (pxl_cen_i) begin
         r_prev <= r_i;
         g_prev <= g_i;
         b_prev <= b_i;
         r_o    <= smooth(r_i, r_prev, bw_en_i);
         g_o    <= smooth(g_i, g_prev, bw_en_i);
         b_o    <= smooth(b_i, b_prev, bw_en_i);
      end
   end

   // timing follows the colour by the same one pixel
   always_ff @(posedge clk) begin
      if (rst_i) begin
         hs_o <= 1'b0;
         vs_o <= 1'b0;
         hb_o <= 1'b1;
         vb_o <= 1'b1;
      end else if (pxl_cen_i) begin
         hs_o <= hs_i;
         vs_o <= vs_i;
         hb_o <= hb_i;
         vb_o <= vb_i;
      end
   end

endmodule

// File: source/vidout_macros.svh
// video output stage widths
// game, filtered and DAC channel sizes, pixel counter and line buffer depth
`ifndef VIDOUT_MACROS_SVH
`define VIDOUT_MACROS_SVH

// game side bits per channel
`define VID_COLORW 4
// after the bandwidth filter
`define VID_FILTW 5
// monitor DAC bits per channel
`define VID_DW 6

// pixel counter, also sizes each line buffer bank
`define VID_HCNTW 9
`define VID_BUF_DEPTH 512

`endif

// File: source/vidout_pkg.sv
// video output stage types
// colour channels at each stage, pixel counts and doubler state
`include "vidout_macros.svh"

package vidout_pkg;

   // one colour channel at each point of the chain
   typedef logic [`VID_COLORW-1:0] game_color_t;
   typedef logic [`VID_FILTW-1:0]  filt_color_t;
   typedef logic [7:0]             full_color_t;
   typedef logic [`VID_DW-1:0]     dac_color_t;

   // pixel position inside a line, or a line length
   typedef logic [`VID_HCNTW-1:0] hcount_t;

   // 0 off, 1..3 dims odd lines by one to three quarters
   typedef logic [1:0] sl_mode_t;

   typedef enum logic [1:0] {
      X2_SEEK,
      X2_MEASURE,
      X2_RUN
   } x2_state_t;

endpackage

// File: source/vidout_top.sv
// video output stage top level
// filter, scan doubler, scanline shader and output stage in a chain
`timescale 1ns/100ps

module vidout_top (
   input  logic                  clk,
   input  logic                  rst_i,
   input  logic                  pxl_cen_i,
   input  logic                  pxl2_cen_i,
   input  logic                  game_hs_i,
   input  logic                  game_vs_i,
   input  logic                  game_hb_i,
   input  logic                  game_vb_i,
   input  vidout_pkg::game_color_t game_r_i,
   input  vidout_pkg::game_color_t game_g_i,
   input  vidout_pkg::game_color_t game_b_i,
   input  logic                  bw_en_i,
   input  logic                  ypbpr_i,
   input  logic                  no_csync_i,
   input  logic                  scan2x_enb_i,
   input  vidout_pkg::sl_mode_t    scanlines_i,
   output vidout_pkg::dac_color_t  video_r_o,
   output vidout_pkg::dac_color_t  video_g_o,
   output vidout_pkg::dac_color_t  video_b_o,
   output logic                  video_hs_o,
   output logic                  video_vs_o,
   output logic                  video_de_o
);
   import vidout_pkg::*;

   // filtered game video
   filt_color_t f_r, f_g, f_b;
   logic        f_hs, f_vs, f_hb, f_vb;

   // doubler control
   hcount_t wr_addr, rd_addr;
   logic    wr_en, bank, odd_line, x2_cen;
   logic    x2_hs, x2_vs, x2_hb, x2_vb;

   // buffer read back and shaded pixels
   filt_color_t lb_r, lb_g, lb_b;
   full_color_t s_r, s_g, s_b;
   logic        s_hs, s_vs, s_de;

   vid_bw_filter u_filter (
      .clk(clk), .rst_i(rst_i), .pxl_cen_i(pxl_cen_i), .bw_en_i(bw_en_i),
      .r_i(game_r_i), .g_i(game_g_i), .b_i(game_b_i),
      .hs_i(game_hs_i), .vs_i(game_vs_i), .hb_i(game_hb_i), .vb_i(game_vb_i),
      .r_o(f_r), .g_o(f_g), .b_o(f_b),
      .hs_o(f_hs), .vs_o(f_vs), .hb_o(f_hb), .vb_o(f_vb)
   );

   scan2x_ctrl u_ctrl (
      .clk(clk), .rst_i(rst_i), .pxl_cen_i(pxl_cen_i), .pxl2_cen_i(pxl2_cen_i),
      .scan2x_enb_i(scan2x_enb_i),
      .hs_i(f_hs), .vs_i(f_vs), .hb_i(f_hb), .vb_i(f_vb),
      .wr_addr_o(wr_addr), .rd_addr_o(rd_addr), .wr_en_o(wr_en), .bank_o(bank),
      .odd_line_o(odd_line),
      .x2_hs_o(x2_hs), .x2_vs_o(x2_vs), .x2_hb_o(x2_hb), .x2_vb_o(x2_vb),
      .x2_cen_o(x2_cen)
   );

   line_buffer u_buffer (
      .clk(clk), .wr_en_i(wr_en), .bank_i(bank),
      .wr_addr_i(wr_addr), .rd_addr_i(rd_addr),
      .wr_r_i(f_r), .wr_g_i(f_g), .wr_b_i(f_b),
      .rd_r_o(lb_r), .rd_g_o(lb_g), .rd_b_o(lb_b)
   );

   // blanks leave the shader only as de
   scanline_shade u_shade (
      .clk(clk), .rst_i(rst_i), .cen_i(x2_cen), .odd_line_i(odd_line),
      .sl_mode_i(scanlines_i),
      .r_i(lb_r), .g_i(lb_g), .b_i(lb_b),
      .hs_i(x2_hs), .vs_i(x2_vs), .hb_i(x2_hb), .vb_i(x2_vb),
      .r_o(s_r), .g_o(s_g), .b_o(s_b),
      .hs_o(s_hs), .vs_o(s_vs), .hb_o(), .vb_o(), .de_o(s_de)
   );

   rgb_ypbpr u_out (
      .clk(clk), .rst_i(rst_i), .ypbpr_i(ypbpr_i), .no_csync_i(no_csync_i),
      .scan2x_enb_i(scan2x_enb_i),
      .r_i(s_r), .g_i(s_g), .b_i(s_b),
      .hs_i(s_hs), .vs_i(s_vs), .de_i(s_de),
      .r_o(video_r_o), .g_o(video_g_o), .b_o(video_b_o),
      .hs_o(video_hs_o), .vs_o(video_vs_o), .de_o(video_de_o)
   );

endmodule

// File: test/vidout_tb.sv
// testbench for the video output stage
// drives a small game frame per table row and checks every active
// output pixel against a model of filter, doubler, shader and matrix
`timescale 1ns/100ps

module vidout_tb;
   import vidout_pkg::*;

   localparam int LINE_W = 24;
   localparam int LINES = 8;
   localparam int FRAME_PIX = LINE_W * LINES;
   localparam int NUM_CASES = 9;

   typedef struct packed {
      logic       bw;
      logic [1:0] sl;
      logic       yp;
      logic       nc;
      logic       enb;
      logic [5:0] per_line;
   } case_t;

   logic clk, rst_i, pxl_cen_i, pxl2_cen_i;
   logic game_hs_i, game_vs_i, game_hb_i, game_vb_i;
   game_color_t game_r_i, game_g_i, game_b_i;
   logic bw_en_i, ypbpr_i, no_csync_i, scan2x_enb_i;
   sl_mode_t scanlines_i;
   dac_color_t video_r_o, video_g_o, video_b_o;
   logic video_hs_o, video_vs_o, video_de_o;

   case_t cases [NUM_CASES];
   logic [31:0] lcg_state;
   logic [3:0] fr_r [FRAME_PIX];
   logic [3:0] fr_g [FRAME_PIX];
   logic [3:0] fr_b [FRAME_PIX];
   logic [3:0] last_r, last_g, last_b;
   logic [5:0] exp_r [$];
   logic [5:0] exp_g [$];
   logic [5:0] exp_b [$];
   logic checking, hs_last;
   int hs_rises, vs_hi, vs_lo, got_pix;

   vidout_top vidout_i (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic stop_run(input string msg);
      $display("%s", msg);
      $display("TB FAILED");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [5:0] got, input logic [5:0] exp);
      assert (got == exp)
      else begin
         $display("Error at %0t: %s got %0d expected %0d", $time, name, got, exp);
         $display("TB FAILED");
         $fatal(1);
      end
   endtask

   // filter, widen to 8 bits and dim, all by integer arithmetic
   function automatic logic [7:0] shade_model(input logic [31:0] cur, input logic [31:0] prev,
                                              input logic bw, input logic odd,
                                              input logic [31:0] mode);
      logic [31:0] f;
      logic [31:0] w;
      f = bw ? cur + prev : cur * 2 + cur / 8;
      w = f * 8 + f / 4;
      if (odd) w = w - mode * (w / 4);
      return w[7:0];
   endfunction

   // one output pixel, plain RGB or Pr Y Pb, cut to 6 bits
   task automatic push_pixel(input logic [7:0] r8, input logic [7:0] g8, input logic [7:0] b8,
                             input logic yp);
      int r, g, b, y, pb, pr;
      logic [31:0] ty, tb, tr;
      r = int'(r8);
      g = int'(g8);
      b = int'(b8);
      y = (77 * r + 150 * g + 29 * b) >>> 8;
      pb = ((128 * b - 43 * r - 85 * g) >>> 8) + 128;
      pr = ((128 * r - 107 * g - 21 * b) >>> 8) + 128;
      ty = yp ? y : g;
      tb = yp ? pb : b;
      tr = yp ? pr : r;
      exp_r.push_back(tr[7:2]);
      exp_g.push_back(ty[7:2]);
      exp_b.push_back(tb[7:2]);
   endtask

   // one sample per output pixel, once its value has settled
   task automatic sample_out();
      logic cond;
      cond = scan2x_enb_i ? pxl_cen_i : pxl2_cen_i;
      if (cond) begin
         if (checking) begin
            if (video_hs_o && !hs_last) hs_rises++;
            if (video_vs_o) vs_hi++;
            else vs_lo++;
            if (video_de_o) begin
               got_pix++;
               assert (exp_r.size() > 0)
               else stop_run("more active output pixels than the frame holds");
               check_value("video_r_o", video_r_o, exp_r.pop_front());
               check_value("video_g_o", video_g_o, exp_g.pop_front());
               check_value("video_b_o", video_b_o, exp_b.pop_front());
            end
         end
         hs_last = video_hs_o;
      end
   endtask

   task automatic tick(input logic cen1, input logic cen2);
      @(negedge clk);
      sample_out();
      pxl_cen_i = cen1;
      pxl2_cen_i = cen2;
   endtask

   // four clocks per game pixel, output pixel rate twice that
   task automatic drive_pixel(input int idx);
      int l, x;
      l = idx / LINE_W;
      x = idx % LINE_W;
      tick(1'b1, 1'b1);
      game_r_i = fr_r[idx];
      game_g_i = fr_g[idx];
      game_b_i = fr_b[idx];
      game_hb_i = (x >= 16);
      game_hs_i = (x == 18) || (x == 19);
      game_vb_i = (l >= 6);
      game_vs_i = (l == 7);
      tick(1'b0, 1'b0);
      tick(1'b0, 1'b1);
      tick(1'b0, 1'b0);
   endtask

   task automatic gen_frame();
      last_r = fr_r[FRAME_PIX-1];
      last_g = fr_g[FRAME_PIX-1];
      last_b = fr_b[FRAME_PIX-1];
      for (int i = 0; i < FRAME_PIX; i++) begin
         lcg_state = lcg_next(lcg_state);
         fr_r[i] = lcg_state[27:24];
         fr_g[i] = lcg_state[23:20];
         fr_b[i] = lcg_state[19:16];
      end
   endtask

   // active lines 0..5, pixels 0..15, each twice when doubled
   task automatic build_expected(input case_t c);
      int i;
      logic [7:0] r8, g8, b8;
      for (int n = 0; n < 6; n++) begin
         for (int h = 0; h < (c.enb ? 1 : 2); h++) begin
            for (int x = 0; x < 16; x++) begin
               i = n * LINE_W + x;
               r8 = shade_model(fr_r[i], (i > 0) ? fr_r[i-1] : last_r, c.bw, h == 1, c.sl);
               g8 = shade_model(fr_g[i], (i > 0) ? fr_g[i-1] : last_g, c.bw, h == 1, c.sl);
               b8 = shade_model(fr_b[i], (i > 0) ? fr_b[i-1] : last_b, c.bw, h == 1, c.sl);
               push_pixel(r8, g8, b8, c.yp);
            end
         end
      end
   endtask

   // frame boundary falls in vblank, output must be idle
   task automatic wait_blank();
      int t;
      t = 0;
      while (video_de_o) begin
         assert (t < 50) else stop_run("video_de_o never went low at the frame boundary");
         drive_pixel(FRAME_PIX - 1);
         t++;
      end
   endtask

   task automatic run_case(input case_t c);
      logic csync;
      int exp_hs;
      bw_en_i = c.bw;
      scanlines_i = c.sl;
      ypbpr_i = c.yp;
      no_csync_i = c.nc;
      scan2x_enb_i = c.enb;
      csync = c.yp | (c.enb & ~c.nc);
      for (int f = 0; f < 3; f++) begin
         wait_blank();
         gen_frame();
         if (f == 2) begin
            build_expected(c);
            hs_rises = 0;
            vs_hi = 0;
            vs_lo = 0;
            got_pix = 0;
            checking = 1'b1;
         end
         for (int i = 0; i < FRAME_PIX; i++) drive_pixel(i);
      end
      checking = 1'b0;
      assert (got_pix == 6 * int'(c.per_line))
      else stop_run($sformatf("Error at %0t: video_de_o pixel count got %0d expected %0d",
                              $time, got_pix, 6 * int'(c.per_line)));
      if (csync) begin
         assert (vs_lo == 0)
         else stop_run("video_vs_o dropped while composite sync was selected");
      end else begin
         assert (vs_hi > 0 && vs_lo > 0)
         else stop_run("video_vs_o showed no vertical sync pulse");
      end
      // hs xor vs, the vsync start adds one rise and the inverted pulses keep one each
      exp_hs = (c.enb ? LINES : 2 * LINES) + (csync ? 1 : 0);
      assert (hs_rises == exp_hs)
      else stop_run($sformatf("Error at %0t: video_hs_o pulses got %0d expected %0d",
                              $time, hs_rises, exp_hs));
   endtask

   initial begin
      rst_i = 1'b1;
      pxl_cen_i = 1'b0;
      pxl2_cen_i = 1'b0;
      {game_hs_i, game_vs_i, game_hb_i, game_vb_i} = 4'b0011;
      game_r_i = '0;
      game_g_i = '0;
      game_b_i = '0;
      {bw_en_i, ypbpr_i, no_csync_i, scan2x_enb_i} = 4'b0000;
      scanlines_i = '0;
      checking = 1'b0;
      hs_last = 1'b0;
      lcg_state = 32'h26e7;
      for (int i = 0; i < FRAME_PIX; i++) begin
         fr_r[i] = '0;
         fr_g[i] = '0;
         fr_b[i] = '0;
      end
      // bw, scanlines, ypbpr, no_csync, bypass, active pixels per input line
      cases[0] = '{1'b0, 2'd0, 1'b0, 1'b0, 1'b0, 6'd32};
      cases[1] = '{1'b1, 2'd0, 1'b0, 1'b0, 1'b0, 6'd32};
      cases[2] = '{1'b0, 2'd1, 1'b0, 1'b0, 1'b0, 6'd32};
      cases[3] = '{1'b1, 2'd2, 1'b0, 1'b1, 1'b0, 6'd32};
      cases[4] = '{1'b0, 2'd3, 1'b0, 1'b0, 1'b0, 6'd32};
      cases[5] = '{1'b0, 2'd0, 1'b1, 1'b0, 1'b0, 6'd32};
      cases[6] = '{1'b0, 2'd0, 1'b0, 1'b0, 1'b1, 6'd16};
      cases[7] = '{1'b1, 2'd0, 1'b0, 1'b1, 1'b1, 6'd16};
      cases[8] = '{1'b0, 2'd2, 1'b1, 1'b1, 1'b1, 6'd16};
      repeat (5) tick(1'b0, 1'b0);
      rst_i = 1'b0;
      for (int k = 0; k < NUM_CASES; k++) run_case(cases[k]);
      $display("TB PASSED");
      $finish;
   end

endmodule

// File: vidout.f
+incdir+source
source/vidout_pkg.sv
source/vid_bw_filter.sv
source/scan2x_ctrl.sv
source/line_buffer.sv
source/scanline_shade.sv
source/rgb_ypbpr.sv
source/vidout_top.sv
test/vidout_tb.sv
